//--- Bender.yml
package:
  name: photon_count

export_include_dirs:
  - include

sources:
  - files:
      - hdl/photon_count_pkg.sv
      - hdl/pulse_front_end.sv
      - hdl/bcd_gate_counter.sv
      - hdl/record_drain.sv
      - hdl/photon_count_top.sv
  - target: test
    files:
      - test/photon_count_assert.sv
      - test/photon_count_tb.sv

//--- flist.f
+incdir+include
hdl/photon_count_pkg.sv
hdl/pulse_front_end.sv
hdl/bcd_gate_counter.sv
hdl/record_drain.sv
hdl/photon_count_top.sv
test/photon_count_assert.sv
test/photon_count_tb.sv

//--- hdl/bcd_gate_counter.sv
`include "photon_count_settings.svh"

module bcd_gate_counter #(
    parameter int unsigned DIGITS = `BCD_DIGITS
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        photon_strobe,
    input  logic                        gate_tick,
    output logic                        rec_valid,
    input  logic                        rec_ready,
    output photon_count_pkg::bcd_count_t rec_count,
    output logic                        rec_overflow,
    output logic                        rec_dropped
);
    import photon_count_pkg::*;

    // Running digits, digit 0 is the units
    bcd_digit_t digit_q [DIGITS];

    // Digits after one increment
    bcd_digit_t digit_inc [DIGITS];

    // Ripple carry, carry[0] is the increment itself
    logic [DIGITS:0] carry;

    // Every digit at nine, next strobe saturates
    logic all_nines;

    // Counter saturated during this gate
    logic overflow_q;

    // Digits packed into record layout
    bcd_count_t count_now;

    // Record handed to the drain on this edge
    logic rec_taken;

    ////////////////////////////////////////
    // Increment path
    ////////////////////////////////////////

    always_comb begin
        // Increment always offered, strobe decides in the flops
        carry[0]  = 1'b1;
        count_now = '0;
        for (int i = 0; i < DIGITS; i++) begin
            if (carry[i]) begin
                // Nine wraps to zero and carries up
                digit_inc[i] = (digit_q[i] == BCD_NINE) ? '0 : digit_q[i] + 1'b1;
            end else begin
                digit_inc[i] = digit_q[i];
            end
            carry[i+1]          = carry[i] & (digit_q[i] == BCD_NINE);
            count_now[4*i +: 4] = digit_q[i];
        end
    end

    // Carry out of the top digit means all nines
    assign all_nines = carry[DIGITS];

    ////////////////////////////////////////
    // Gated counter
    ////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < DIGITS; i++) begin
                digit_q[i] <= '0;
            end
            overflow_q <= 1'b0;
        end else if (gate_tick) begin
            // New gate, a coincident strobe is its first count
            for (int i = 0; i < DIGITS; i++) begin
                digit_q[i] <= '0;
            end
            digit_q[0] <= bcd_digit_t'(photon_strobe);
            overflow_q <= 1'b0;
        end else if (photon_strobe) begin
            // Hold at all nines and flag it
            if (all_nines) begin
                overflow_q <= 1'b1;
            end else begin
                digit_q <= digit_inc;
            end
        end
    end

    ////////////////////////////////////////
    // Record register
    ////////////////////////////////////////

    assign rec_taken = rec_valid & rec_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rec_valid    <= 1'b0;
            rec_count    <= '0;
            rec_overflow <= 1'b0;
            rec_dropped  <= 1'b0;
        end else if (gate_tick) begin
            rec_valid    <= 1'b1;
            rec_count    <= count_now;
            rec_overflow <= overflow_q;
            // Old record still waiting and not taken now
            rec_dropped  <= rec_valid & ~rec_ready;
        end else if (rec_taken) begin
            rec_valid <= 1'b0;
        end
    end

endmodule

//--- hdl/photon_count_pkg.sv
`include "photon_count_settings.svh"

package photon_count_pkg;

    ////////////////////////////////////////
    // Sizes derived from the settings
    ////////////////////////////////////////

    // Photon lines plus the mains sync line
    localparam int unsigned NUM_LINES = `NUM_CHANNELS + 1;

    // Widest count a record can carry
    localparam int unsigned MAX_DIGITS = 8;

    // Channel tag width, never below one bit
    localparam int unsigned CHAN_IDX_W =
        (`NUM_CHANNELS > 1) ? $clog2(`NUM_CHANNELS) : 1;

    ////////////////////////////////////////
    // Count and record types
    ////////////////////////////////////////

    // One decimal digit
    typedef logic [3:0] bcd_digit_t;

    // Top value of a digit, wrap point of the ripple
    localparam bcd_digit_t BCD_NINE = 4'd9;

    // Eight packed digits, digit 0 in bits 3:0
    // Digits above the counter size read as zero
    typedef logic [4*MAX_DIGITS-1:0] bcd_count_t;

    // Channel number attached to each output record
    typedef logic [CHAN_IDX_W-1:0] chan_idx_t;

endpackage

//--- hdl/photon_count_top.sv
`include "photon_count_settings.svh"

module photon_count_top #(
    parameter int unsigned DIGITS = `BCD_DIGITS
) (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         en,
    input  logic [`NUM_CHANNELS-1:0]     photon_pulse,
    input  logic                         sync_in,
    output logic                         out_valid,
    input  logic                         out_ready,
    output photon_count_pkg::chan_idx_t  out_chan,
    output photon_count_pkg::bcd_count_t out_count,
    output logic                         out_overflow,
    output logic                         out_dropped
);
    import photon_count_pkg::*;

    // Conditioned strobes from the front end
    logic [`NUM_CHANNELS-1:0] photon_strobe;
    logic                     gate_tick;

    // Record links between counters and drain
    logic [`NUM_CHANNELS-1:0] rec_valid;
    logic [`NUM_CHANNELS-1:0] rec_ready;
    bcd_count_t               rec_count [`NUM_CHANNELS];
    logic [`NUM_CHANNELS-1:0] rec_overflow;
    logic [`NUM_CHANNELS-1:0] rec_dropped;

    ////////////////////////////////////////
    // Input synchronizers and edge strobes
    ////////////////////////////////////////

    pulse_front_end u_front_end (
        .clk           (clk),
        .rst_n         (rst_n),
        .en            (en),
        .photon_pulse  (photon_pulse),
        .sync_in       (sync_in),
        .photon_strobe (photon_strobe),
        .gate_tick     (gate_tick)
    );

    ////////////////////////////////////////
    // One gated counter per channel
    ////////////////////////////////////////

    for (genvar i = 0; i < `NUM_CHANNELS; i++) begin : g_chan
        // All channels share the gate tick
        bcd_gate_counter #(
            .DIGITS (DIGITS)
        ) u_counter (
            .clk           (clk),
            .rst_n         (rst_n),
            .photon_strobe (photon_strobe[i]),
            .gate_tick     (gate_tick),
            .rec_valid     (rec_valid[i]),
            .rec_ready     (rec_ready[i]),
            .rec_count     (rec_count[i]),
            .rec_overflow  (rec_overflow[i]),
            .rec_dropped   (rec_dropped[i])
        );
    end

    ////////////////////////////////////////
    // Merge records onto the output stream
    ////////////////////////////////////////

    record_drain u_drain (
        .clk          (clk),
        .rst_n        (rst_n),
        .rec_valid    (rec_valid),
        .rec_ready    (rec_ready),
        .rec_count    (rec_count),
        .rec_overflow (rec_overflow),
        .rec_dropped  (rec_dropped),
        .out_valid    (out_valid),
        .out_ready    (out_ready),
        .out_chan     (out_chan),
        .out_count    (out_count),
        .out_overflow (out_overflow),
        .out_dropped  (out_dropped)
    );

endmodule

//--- hdl/pulse_front_end.sv
`include "photon_count_settings.svh"

module pulse_front_end (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     en,
    input  logic [`NUM_CHANNELS-1:0] photon_pulse,
    input  logic                     sync_in,
    output logic [`NUM_CHANNELS-1:0] photon_strobe,
    output logic                     gate_tick
);
    import photon_count_pkg::*;

    ////////////////////////////////////////
    // Input lines
    ////////////////////////////////////////

    // Photon lines below, mains sync on the top bit
    logic [NUM_LINES-1:0] raw_lines;

    // Synchronizer chain, stage 0 samples the pins
    logic [NUM_LINES-1:0] sync_ff [`SYNC_STAGES];

    // Synchronized level and its value one cycle back
    logic [NUM_LINES-1:0] level_q;
    logic [NUM_LINES-1:0] prev_q;

    // Registered one-cycle edge strobes
    logic [NUM_LINES-1:0] strobe_q;

    assign raw_lines = {sync_in, photon_pulse};

    ////////////////////////////////////////
    // Synchronize and detect rising edges
    ////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int s = 0; s < `SYNC_STAGES; s++) begin
                sync_ff[s] <= '0;
            end
            level_q  <= '0;
            prev_q   <= '0;
            strobe_q <= '0;
        end else begin
            // Metastability chain
            sync_ff[0] <= raw_lines;
            for (int s = 1; s < `SYNC_STAGES; s++) begin
                sync_ff[s] <= sync_ff[s-1];
            end

            // Level keeps tracking while disabled
            // So a line already high at enable gives no edge
            level_q <= sync_ff[`SYNC_STAGES-1];
            prev_q  <= level_q;

            // Rising edge, masked by enable
            strobe_q <= {NUM_LINES{en}} & level_q & ~prev_q;
        end
    end

    ////////////////////////////////////////
    // Split strobes back out
    ////////////////////////////////////////

    // One strobe per photon channel
    assign photon_strobe = strobe_q[`NUM_CHANNELS-1:0];

    // Gate boundary from the mains sync line
    assign gate_tick = strobe_q[`NUM_CHANNELS];

endmodule

//--- hdl/record_drain.sv
`include "photon_count_settings.svh"

module record_drain (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic [`NUM_CHANNELS-1:0]     rec_valid,
    output logic [`NUM_CHANNELS-1:0]     rec_ready,
    input  photon_count_pkg::bcd_count_t rec_count [`NUM_CHANNELS],
    input  logic [`NUM_CHANNELS-1:0]     rec_overflow,
    input  logic [`NUM_CHANNELS-1:0]     rec_dropped,
    output logic                         out_valid,
    input  logic                         out_ready,
    output photon_count_pkg::chan_idx_t  out_chan,
    output photon_count_pkg::bcd_count_t out_count,
    output logic                         out_overflow,
    output logic                         out_dropped
);
    import photon_count_pkg::*;

    localparam int unsigned N = `NUM_CHANNELS;

    // First channel looked at in the next search
    chan_idx_t ptr_q;

    // Channel picked this cycle, valid with grant_any
    chan_idx_t grant_idx;
    logic      grant_any;

    // Pointer position after the granted channel
    chan_idx_t next_ptr;

    // Output register free or emptying on this edge
    logic load_ok;

    // One-hot ready back to the counters
    logic [N-1:0] grant_vec;

    assign load_ok = ~out_valid | out_ready;

    ////////////////////////////////////////
    // Round-robin search
    ////////////////////////////////////////

    always_comb begin
        int unsigned idx;
        grant_any = 1'b0;
        grant_idx = '0;
        grant_vec = '0;
        // Walk from the pointer and wrap once
        for (int unsigned k = 0; k < N; k++) begin
            idx = ptr_q + k;
            if (idx >= N) begin
                idx = idx - N;
            end
            if (!grant_any && rec_valid[idx]) begin
                grant_any = 1'b1;
                grant_idx = chan_idx_t'(idx);
            end
        end
        // No ready while the register is stuck
        if (grant_any && load_ok) begin
            grant_vec[grant_idx] = 1'b1;
        end
    end

    assign rec_ready = grant_vec;

    // Step past the grant, wrap at the last channel
    assign next_ptr = (grant_idx == chan_idx_t'(N - 1)) ? '0 : grant_idx + 1'b1;

    ////////////////////////////////////////
    // Output register
    ////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ptr_q        <= '0;
            out_valid    <= 1'b0;
            out_chan     <= '0;
            out_count    <= '0;
            out_overflow <= 1'b0;
            out_dropped  <= 1'b0;
        end else if (load_ok) begin
            if (grant_any) begin
                // Tag the record with its channel
                out_valid    <= 1'b1;
                out_chan     <= grant_idx;
                out_count    <= rec_count[grant_idx];
                out_overflow <= rec_overflow[grant_idx];
                out_dropped  <= rec_dropped[grant_idx];
                ptr_q        <= next_ptr;
            end else begin
                // Nothing waiting, drop valid after the transfer
                out_valid <= 1'b0;
            end
        end
    end

endmodule

//--- include/photon_count_settings.svh
`ifndef PHOTON_COUNT_SETTINGS_SVH
`define PHOTON_COUNT_SETTINGS_SVH

////////////////////////////////////////
// Channel and counter sizing
////////////////////////////////////////

// Photon inputs, one counter each
`define NUM_CHANNELS 4

// Default BCD digits per counter, 8 at most
`define BCD_DIGITS 8

////////////////////////////////////////
// Input conditioning
////////////////////////////////////////

// Flops in each input synchronizer
`define SYNC_STAGES 2

`endif

//--- test/photon_count_assert.sv
module photon_count_assert (
    input logic                         clk,
    input logic                         rst_n,
    input logic                         out_valid,
    input logic                         out_ready,
    input photon_count_pkg::chan_idx_t  out_chan,
    input photon_count_pkg::bcd_count_t out_count,
    input logic                         out_overflow,
    input logic                         out_dropped
);
    import photon_count_pkg::*;

    // Read by the testbench summary
    int fail_count = 0;

    function automatic logic digits_ok(bcd_count_t c);
        logic ok;
        ok = 1'b1;
        for (int i = 0; i < MAX_DIGITS; i++) begin
            if (c[4*i +: 4] > BCD_NINE) begin
                ok = 1'b0;
            end
        end
        return ok;
    endfunction

    // Stalled record holds valid and payload
    a_hold: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && !out_ready |=> out_valid && $stable(out_chan) && $stable(out_count)
            && $stable(out_overflow) && $stable(out_dropped))
        else begin
            $error("output record changed while stalled");
            fail_count++;
        end

    a_reset: assert property (@(posedge clk) !rst_n |-> !out_valid)
        else begin
            $error("out_valid high during reset");
            fail_count++;
        end

    // Each nibble a decimal digit
    a_digits: assert property (@(posedge clk) disable iff (!rst_n) digits_ok(out_count))
        else begin
            $error("out_count holds a digit above nine");
            fail_count++;
        end

endmodule

bind photon_count_top photon_count_assert u_assert (.*);

//--- test/photon_count_tb.sv
`include "photon_count_settings.svh"

module photon_count_tb;
    import photon_count_pkg::*;

    localparam int NCH       = `NUM_CHANNELS;
    localparam int DIGITS    = 3;
    localparam int MAX_COUNT = 10 ** DIGITS - 1;
    localparam int RX_LIMIT  = 40;
    // Longest pulse train of each test at four cycles per pulse
    // Eight gates of overhead plus margin
    localparam int WATCHDOG_CYCLES = 4 * (64 + 11 + 1009 + 18 + 9 + 10) + 8 * 60 + 500;

    logic           clk;
    logic           rst_n;
    logic           en;
    logic           sync_in;
    logic           out_ready;
    logic [NCH-1:0] photon_pulse;
    logic           out_valid;
    logic           out_overflow;
    logic           out_dropped;
    chan_idx_t      out_chan;
    bcd_count_t     out_count;

    integer seed         = 32'h60da;
    int     errors       = 0;
    int     tests_failed = 0;
    // Model of the drain pointer
    int     exp_ptr      = 0;
    // Pulses driven per channel in the current gate
    int     want [NCH];

    photon_count_top #(.DIGITS(DIGITS)) UUT (.*);

    always #50 clk = ~clk;

    ////////////////////////////////////////
    // Reference model and stimulus helpers
    ////////////////////////////////////////

    function automatic bcd_count_t to_bcd(int n);
        bcd_count_t b;
        b = '0;
        for (int i = 0; i < MAX_DIGITS; i++) begin
            b[4*i +: 4] = 4'(n % 10);
            n = n / 10;
        end
        return b;
    endfunction

    // Each pulse two cycles high and two cycles low on every busy channel
    task automatic drive_pulses();
        int left [NCH];
        int busy;
        left = want;
        busy = 1;
        while (busy != 0) begin
            busy = 0;
            for (int c = 0; c < NCH; c++) begin
                photon_pulse[c] = (left[c] > 0);
                if (left[c] > 0) begin
                    left[c]--;
                    busy = 1;
                end
            end
            repeat (2) @(negedge clk);
            photon_pulse = '0;
            repeat (2) @(negedge clk);
        end
    endtask

    // Mains edge closes the gate
    task automatic sync_edge();
        sync_in = 1'b1;
        repeat (2) @(negedge clk);
        sync_in = 1'b0;
    endtask

    task automatic receive_record(output int ch, output bcd_count_t cnt,
                                  output logic ovf, output logic drp, output logic got);
        int waited;
        waited = 0;
        got = 1'b0;
        while (!(out_valid && out_ready)) begin
            if (waited == RX_LIMIT) begin
                $display("No output record arrived within %0d cycles, time %0t", RX_LIMIT, $time);
                errors++;
                return;
            end
            @(negedge clk);
            waited++;
        end
        ch  = out_chan;
        cnt = out_count;
        ovf = out_overflow;
        drp = out_dropped;
        got = 1'b1;
        // Transfer on the coming rising edge
        @(negedge clk);
    endtask

    task automatic check_record(input int ch, input bcd_count_t cnt, input logic ovf,
                                input logic drp, input int pulses, input logic exp_drp);
        bcd_count_t exp_cnt;
        exp_cnt = to_bcd((pulses > MAX_COUNT) ? MAX_COUNT : pulses);
        if (ch != exp_ptr) begin
            $display("CHECK FAILED at %0t: channel %0d arrived, expected %0d", $time, ch, exp_ptr);
            errors++;
        end
        if (cnt !== exp_cnt || ovf !== (pulses > MAX_COUNT) || drp !== exp_drp) begin
            $display("CHECK FAILED at %0t: ch %0d got %h ovf %b drp %b, expected %h ovf %b drp %b",
                     $time, ch, cnt, ovf, drp, exp_cnt, pulses > MAX_COUNT, exp_drp);
            errors++;
        end
        exp_ptr = (exp_ptr + 1) % NCH;
    endtask

    // One record per channel in pointer order
    task automatic collect_gate(input logic [NCH-1:0] drp_mask);
        logic [NCH-1:0] seen;
        int             ch;
        bcd_count_t     cnt;
        logic           ovf;
        logic           drp;
        logic           got;
        seen = '0;
        repeat (NCH) begin
            receive_record(ch, cnt, ovf, drp, got);
            if (!got) begin
                return;
            end
            if (seen[ch]) begin
                $display("Channel %0d reported twice in one gate, time %0t", ch, $time);
                errors++;
            end
            seen[ch] = 1'b1;
            check_record(ch, cnt, ovf, drp, want[ch], drp_mask[ch]);
        end
    endtask

    task automatic end_test(input string name, input int start);
        if (errors == start) begin
            $display("%-14s passed", name);
        end else begin
            $display("%-14s failed with %0d errors", name, errors - start);
            tests_failed++;
        end
    endtask

    ////////////////////////////////////////
    // Directed tests
    ////////////////////////////////////////

    task automatic test_counting();
        int start;
        start = errors;
        for (int c = 0; c < NCH; c++) begin
            want[c] = $random(seed) & 63;
        end
        drive_pulses();
        sync_edge();
        collect_gate('0);
        end_test("counting", start);
    endtask

    // All records wait behind a stalled output
    task automatic test_round_robin();
        int start;
        start = errors;
        for (int c = 0; c < NCH; c++) begin
            want[c] = 3 * c + 2;
        end
        drive_pulses();
        out_ready = 1'b0;
        sync_edge();
        repeat (6) @(negedge clk);
        out_ready = 1'b1;
        collect_gate('0);
        end_test("round_robin", start);
    endtask

    task automatic test_overflow();
        int start;
        start = errors;
        for (int c = 0; c < NCH; c++) begin
            want[c] = c + 1;
        end
        want[2] = MAX_COUNT + 3;
        drive_pulses();
        sync_edge();
        collect_gate('0);
        // Next gate starts clean
        for (int c = 0; c < NCH; c++) begin
            want[c] = c + 4;
        end
        drive_pulses();
        sync_edge();
        collect_gate('0);
        end_test("overflow", start);
    endtask

    task automatic test_back_pressure();
        int             start;
        int             first;
        int             gate_a [NCH];
        int             ch;
        bcd_count_t     cnt;
        logic           ovf;
        logic           drp;
        logic           got;
        logic [NCH-1:0] mask;
        start = errors;
        out_ready = 1'b0;
        for (int c = 0; c < NCH; c++) begin
            want[c] = c + 2;
        end
        gate_a = want;
        first = exp_ptr;
        drive_pulses();
        sync_edge();
        for (int c = 0; c < NCH; c++) begin
            want[c] = 2 * c + 7;
        end
        drive_pulses();
        sync_edge();
        repeat (6) @(negedge clk);
        out_ready = 1'b1;
        // First gate record already sat in the output register
        receive_record(ch, cnt, ovf, drp, got);
        if (got) begin
            check_record(ch, cnt, ovf, drp, gate_a[ch], 1'b0);
        end
        // Its channel was emptied in time and sees no overwrite
        mask = '1;
        mask[first] = 1'b0;
        collect_gate(mask);
        end_test("back_pressure", start);
    endtask

    task automatic test_enable();
        int start;
        start = errors;
        en = 1'b0;
        for (int c = 0; c < NCH; c++) begin
            want[c] = 5;
        end
        drive_pulses();
        sync_edge();
        repeat (12) begin
            @(negedge clk);
            if (out_valid) begin
                $display("CHECK FAILED at %0t: out_valid high while disabled", $time);
                errors++;
            end
        end
        en = 1'b1;
        for (int c = 0; c < NCH; c++) begin
            want[c] = c + 1;
        end
        drive_pulses();
        sync_edge();
        collect_gate('0);
        end_test("enable", start);
    endtask

    ////////////////////////////////////////
    // Watchdog and main sequence
    ////////////////////////////////////////

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Watchdog expired after %0d cycles, a test stalled", WATCHDOG_CYCLES);
        $display("SIMULATION FAILED");
        $finish;
    end

    initial begin
        clk          = 1'b0;
        rst_n        = 1'b0;
        en           = 1'b1;
        sync_in      = 1'b0;
        out_ready    = 1'b1;
        photon_pulse = '0;
        repeat (4) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        test_counting();
        test_round_robin();
        test_overflow();
        test_back_pressure();
        test_enable();
        errors += UUT.u_assert.fail_count;
        $display("Tests 5, failed %0d, errors %0d, assertion failures %0d",
                 tests_failed, errors, UUT.u_assert.fail_count);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule
